/* Makefile */
# Verilator build and run for the GMII transmitter testbench

VERILATOR ?= verilator
TOP ?= gmii_tx_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '^sim passed$$' $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
src/gmii_tx_pkg.sv
src/gmii_tx_crc32.sv
src/gmii_tx_hdr_class.sv
src/gmii_tx_ctrl.sv
src/gmii_tx_top.sv
verif/gmii_tx_tb.sv

/* src/gmii_tx_crc32.sv */
// Ethernet CRC-32 register, reflected, one byte per update
module gmii_tx_crc32 (
    input  logic                    clk,
    input  logic                    crc_init,
    input  logic                    crc_update,
    input  gmii_tx_pkg::gmii_byte_t crc_data,
    output gmii_tx_pkg::crc_t       crc_state
);

    import gmii_tx_pkg::*;

    // 0x04C11DB7 with its bits reversed, for LSB-first shifting
    localparam crc_t CRC_POLY_REFL = 32'hEDB88320;

    crc_t crc_reg;

    // eight serial steps, data bit 0 first
    function automatic crc_t crc_step(input crc_t crc_in, input gmii_byte_t data);
        crc_t crc;
        crc = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (crc[0] ^ data[i]) begin
                crc = (crc >> 1) ^ CRC_POLY_REFL;
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clk) begin
        if (crc_init) begin
            crc_reg <= '1;
        end else if (crc_update) begin
            crc_reg <= crc_step(crc_reg, crc_data);
        end
    end

    assign crc_state = crc_reg;

    // the sequencer never restarts the remainder while feeding it
    a_init_update_excl: assert property (
        @(posedge clk) !(crc_init && crc_update)
    );

endmodule

/* src/gmii_tx_ctrl.sv */
// GMII transmit sequencer with padding, FCS, gap, error marking and statistics
module gmii_tx_ctrl #(
    parameter int MIN_FRAME_LEN = 64,
    parameter bit PADDING_EN = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  gmii_tx_pkg::gmii_byte_t tdata,
    input  logic                    tvalid,
    input  logic                    tlast,
    input  logic                    tuser,
    output logic                    tready,
    input  gmii_tx_pkg::pkt_len_t   cfg_tx_max_pkt_len,
    input  gmii_tx_pkg::ifg_len_t   cfg_tx_ifg,
    input  logic                    cfg_tx_enable,
    output logic                    crc_init,
    output logic                    crc_update,
    output gmii_tx_pkg::gmii_byte_t crc_data,
    input  gmii_tx_pkg::crc_t       crc_state,
    output logic                    hdr_start,
    output logic                    hdr_byte_valid,
    output gmii_tx_pkg::gmii_byte_t hdr_data,
    input  logic                    is_mcast,
    input  logic                    is_bcast,
    input  logic                    is_vlan,
    output gmii_tx_pkg::gmii_byte_t gmii_txd,
    output logic                    gmii_tx_en,
    output logic                    gmii_tx_er,
    output logic                    tx_start_packet,
    output logic                    stat_tx_byte,
    output gmii_tx_pkg::pkt_len_t   stat_tx_pkt_len,
    output logic                    stat_tx_pkt_ucast,
    output logic                    stat_tx_pkt_mcast,
    output logic                    stat_tx_pkt_bcast,
    output logic                    stat_tx_pkt_vlan,
    output logic                    stat_tx_pkt_good,
    output logic                    stat_tx_pkt_bad,
    output logic                    stat_tx_err_oversize,
    output logic                    stat_tx_err_user,
    output logic                    stat_tx_err_underflow
);

    import gmii_tx_pkg::*;

    localparam int MIN_LEN_W = $clog2(MIN_FRAME_LEN - FCS_LEN);
    localparam logic [MIN_LEN_W-1:0] MIN_CNT_INIT = MIN_LEN_W'(MIN_FRAME_LEN - FCS_LEN - 1);
    localparam logic [2:0] PRE_CNT_INIT = 3'(PREAMBLE_LEN - 1);
    localparam logic [1:0] FCS_PTR_LAST = 2'(FCS_LEN - 1);

    tx_state_t state;
    gmii_byte_t s_tdata;

    logic [2:0] pre_cnt;
    logic [MIN_LEN_W-1:0] min_cnt;
    logic [1:0] fcs_ptr;
    pkt_len_t frame_len;
    pkt_len_t len_lim;
    ifg_len_t ifg_cnt;

    logic frame_reg;
    logic frame_next;
    logic in_frame;
    logic payload_end;
    logic stat_pend;
    logic err_user_flag;
    logic err_underflow_flag;
    logic err_oversize_flag;
    logic frame_error;

    // frame_reg is high while the source is mid-frame
    assign frame_next = (tvalid && tready) ? !tlast : frame_reg;
    assign in_frame = state inside {TX_PAYLOAD, TX_LAST, TX_PAD, TX_FCS};

    // limit check looks ahead over the held byte and the FCS
    assign payload_end = !tvalid || tlast || (len_lim < 6);
    assign frame_error = err_user_flag || err_underflow_flag || err_oversize_flag;

    assign crc_init = state inside {TX_IDLE, TX_PREAMBLE};
    assign crc_update = state inside {TX_PAYLOAD, TX_LAST, TX_PAD};
    assign crc_data = s_tdata;
    assign hdr_start = crc_init;
    assign hdr_byte_valid = crc_update;
    assign hdr_data = s_tdata;

    // one byte of lookahead between the stream and GMII
    always_ff @(posedge clk) begin
        case (state)
            TX_PREAMBLE: if (pre_cnt <= 3'd1) s_tdata <= tdata;
            TX_PAYLOAD: s_tdata <= tdata;
            TX_LAST, TX_PAD: s_tdata <= '0;
            default: s_tdata <= s_tdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= TX_IDLE;
            frame_reg <= 1'b0;
            tready <= 1'b0;
            pre_cnt <= '0;
            min_cnt <= '0;
            fcs_ptr <= '0;
            frame_len <= '0;
            len_lim <= '0;
            ifg_cnt <= '0;
            stat_pend <= 1'b0;
            err_user_flag <= 1'b0;
            err_underflow_flag <= 1'b0;
            err_oversize_flag <= 1'b0;
            gmii_txd <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
            tx_start_packet <= 1'b0;
            stat_tx_byte <= 1'b0;
            stat_tx_pkt_len <= '0;
            stat_tx_pkt_ucast <= 1'b0;
            stat_tx_pkt_mcast <= 1'b0;
            stat_tx_pkt_bcast <= 1'b0;
            stat_tx_pkt_vlan <= 1'b0;
            stat_tx_pkt_good <= 1'b0;
            stat_tx_pkt_bad <= 1'b0;
            stat_tx_err_oversize <= 1'b0;
            stat_tx_err_user <= 1'b0;
            stat_tx_err_underflow <= 1'b0;
        end else begin
            frame_reg <= frame_next;
            tready <= 1'b0;
            stat_pend <= 1'b0;
            gmii_txd <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
            tx_start_packet <= 1'b0;
            stat_tx_byte <= 1'b0;
            stat_tx_pkt_len <= '0;
            stat_tx_pkt_ucast <= 1'b0;
            stat_tx_pkt_mcast <= 1'b0;
            stat_tx_pkt_bcast <= 1'b0;
            stat_tx_pkt_vlan <= 1'b0;
            stat_tx_pkt_good <= 1'b0;
            stat_tx_pkt_bad <= 1'b0;
            stat_tx_err_oversize <= 1'b0;
            stat_tx_err_user <= 1'b0;
            stat_tx_err_underflow <= 1'b0;

            // per-frame counters, held through the gap for the statistics
            if (crc_init) begin
                frame_len <= '0;
                len_lim <= cfg_tx_max_pkt_len;
                min_cnt <= MIN_CNT_INIT;
                err_user_flag <= 1'b0;
                err_underflow_flag <= 1'b0;
                err_oversize_flag <= 1'b0;
            end else if (in_frame) begin
                if (!(&frame_len)) frame_len <= frame_len + 1'b1;
                if (len_lim != '0) len_lim <= len_lim - 1'b1;
                if (min_cnt != '0) min_cnt <= min_cnt - 1'b1;
            end
            if (pre_cnt != '0) pre_cnt <= pre_cnt - 1'b1;
            if (ifg_cnt != '0) ifg_cnt <= ifg_cnt - 1'b1;

            case (state)
                TX_IDLE: begin
                    pre_cnt <= PRE_CNT_INIT;
                    if (tvalid && cfg_tx_enable) begin
                        gmii_txd <= ETH_PRE;
                        gmii_tx_en <= 1'b1;
                        state <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    gmii_txd <= ETH_PRE;
                    gmii_tx_en <= 1'b1;
                    if (pre_cnt == 3'd1) begin
                        tready <= 1'b1;
                    end else if (pre_cnt == '0) begin
                        tready <= 1'b1;
                        gmii_txd <= ETH_SFD;
                        stat_tx_byte <= 1'b1;
                        state <= TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    gmii_txd <= s_tdata;
                    gmii_tx_en <= 1'b1;
                    stat_tx_byte <= 1'b1;
                    tready <= 1'b1;
                    // SFD is on the wire during the first payload cycle
                    tx_start_packet <= frame_len == '0;
                    if (payload_end) begin
                        tready <= frame_next;
                        err_user_flag <= tvalid && tuser;
                        err_underflow_flag <= !tvalid;
                        err_oversize_flag <= len_lim < 6;
                        state <= TX_LAST;
                    end
                end
                TX_LAST, TX_PAD: begin
                    gmii_txd <= s_tdata;
                    gmii_tx_en <= 1'b1;
                    gmii_tx_er <= frame_error;
                    stat_tx_byte <= 1'b1;
                    tready <= frame_next;
                    fcs_ptr <= '0;
                    if (PADDING_EN && min_cnt != '0) begin
                        state <= TX_PAD;
                    end else begin
                        state <= TX_FCS;
                    end
                end
                TX_FCS: begin
                    gmii_txd <= ~crc_state[8*fcs_ptr +: 8];
                    gmii_tx_en <= 1'b1;
                    gmii_tx_er <= frame_error;
                    stat_tx_byte <= 1'b1;
                    tready <= frame_next;
                    ifg_cnt <= cfg_tx_ifg;
                    if (fcs_ptr != FCS_PTR_LAST) begin
                        fcs_ptr <= fcs_ptr + 1'b1;
                    end else begin
                        stat_pend <= 1'b1;
                        state <= TX_IFG;
                    end
                end
                TX_IFG: begin
                    // keep draining whatever is left of a cut frame
                    tready <= frame_next;
                    if (stat_pend) begin
                        stat_tx_pkt_len <= frame_len;
                        stat_tx_pkt_good <= !frame_error;
                        stat_tx_pkt_bad <= frame_error;
                        stat_tx_pkt_ucast <= !is_mcast;
                        stat_tx_pkt_mcast <= is_mcast && !is_bcast;
                        stat_tx_pkt_bcast <= is_bcast;
                        stat_tx_pkt_vlan <= is_vlan;
                        stat_tx_err_oversize <= err_oversize_flag;
                        stat_tx_err_user <= err_user_flag;
                        stat_tx_err_underflow <= err_underflow_flag;
                    end
                    if (ifg_cnt <= ifg_len_t'(1) && !frame_reg) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    a_er_in_frame: assert property (
        @(posedge clk) disable iff (reset_crc) gmii_tx_er |-> gmii_tx_en
    );

    // nothing is taken from the source between frames
    a_no_ready_idle: assert property (
        @(posedge clk) disable iff (reset_crc) (state == TX_IDLE) |-> !tready
    );

endmodule

/* src/gmii_tx_hdr_class.sv */
// destination address and VLAN tag classifier over the outgoing frame bytes
module gmii_tx_hdr_class (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  logic                    hdr_start,
    input  logic                    hdr_byte_valid,
    input  gmii_tx_pkg::gmii_byte_t hdr_data,
    output logic                    is_mcast,
    output logic                    is_bcast,
    output logic                    is_vlan
);

    import gmii_tx_pkg::*;

    localparam gmii_byte_t BCAST_BYTE = 8'hFF;

    // 802.1Q tag protocol identifier 0x8100
    localparam gmii_byte_t TPID_HI = 8'h81;
    localparam gmii_byte_t TPID_LO = 8'h00;

    logic [HDR_PTR_W-1:0] hdr_ptr;

    // saturates past the ethertype
    always_ff @(posedge clk) begin
        if (reset_crc || hdr_start) begin
            hdr_ptr <= '0;
        end else if (hdr_byte_valid && !(&hdr_ptr)) begin
            hdr_ptr <= hdr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            is_mcast <= 1'b0;
            is_bcast <= 1'b0;
            is_vlan <= 1'b0;
        end else if (hdr_byte_valid) begin
            case (hdr_ptr)
                0: begin
                    // group bit of the destination
                    is_mcast <= hdr_data[0];
                    is_bcast <= hdr_data == BCAST_BYTE;
                end
                1, 2, 3, 4, 5: begin
                    is_bcast <= is_bcast && (hdr_data == BCAST_BYTE);
                end
                12: begin
                    is_vlan <= hdr_data == TPID_HI;
                end
                13: begin
                    is_vlan <= is_vlan && (hdr_data == TPID_LO);
                end
                default: begin
                    // source address and beyond
                end
            endcase
        end
    end

endmodule

/* src/gmii_tx_pkg.sv */
// GMII transmitter shared types, frame constants and the FSM state encoding
package gmii_tx_pkg;

    // one byte on the input stream and on GMII
    typedef logic [7:0] gmii_byte_t;

    // frame lengths and length limits, in bytes
    typedef logic [15:0] pkt_len_t;

    // inter-frame gap in byte times
    typedef logic [7:0] ifg_len_t;

    // running CRC-32 remainder, reflected
    typedef logic [31:0] crc_t;

    typedef enum logic [2:0] {
        TX_IDLE     = 3'd0,
        TX_PREAMBLE = 3'd1,
        TX_PAYLOAD  = 3'd2,
        TX_LAST     = 3'd3,
        TX_PAD      = 3'd4,
        TX_FCS      = 3'd5,
        TX_IFG      = 3'd6
    } tx_state_t;

    // preamble byte and start-of-frame delimiter
    localparam gmii_byte_t ETH_PRE = 8'h55;
    localparam gmii_byte_t ETH_SFD = 8'hD5;

    // preamble bytes ahead of the SFD
    localparam int PREAMBLE_LEN = 7;

    // frame check sequence length in bytes
    localparam int FCS_LEN = 4;

    // header byte pointer, enough for bytes 0 to 13
    localparam int HDR_PTR_W = 4;

endpackage

/* src/gmii_tx_top.sv */
// GMII frame transmitter top, joining the sequencer, CRC and header classifier
module gmii_tx_top #(
    parameter int MIN_FRAME_LEN = 64,
    parameter bit PADDING_EN = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset_crc,
    input  gmii_tx_pkg::gmii_byte_t tdata,
    input  logic                    tvalid,
    input  logic                    tlast,
    input  logic                    tuser,
    output logic                    tready,
    input  gmii_tx_pkg::pkt_len_t   cfg_tx_max_pkt_len,
    input  gmii_tx_pkg::ifg_len_t   cfg_tx_ifg,
    input  logic                    cfg_tx_enable,
    output gmii_tx_pkg::gmii_byte_t gmii_txd,
    output logic                    gmii_tx_en,
    output logic                    gmii_tx_er,
    output logic                    tx_start_packet,
    output logic                    stat_tx_byte,
    output gmii_tx_pkg::pkt_len_t   stat_tx_pkt_len,
    output logic                    stat_tx_pkt_ucast,
    output logic                    stat_tx_pkt_mcast,
    output logic                    stat_tx_pkt_bcast,
    output logic                    stat_tx_pkt_vlan,
    output logic                    stat_tx_pkt_good,
    output logic                    stat_tx_pkt_bad,
    output logic                    stat_tx_err_oversize,
    output logic                    stat_tx_err_user,
    output logic                    stat_tx_err_underflow
);

    import gmii_tx_pkg::*;

    logic crc_init;
    logic crc_update;
    gmii_byte_t crc_data;
    crc_t crc_state;

    logic hdr_start;
    logic hdr_byte_valid;
    gmii_byte_t hdr_data;
    logic is_mcast;
    logic is_bcast;
    logic is_vlan;

    gmii_tx_ctrl #(
        .MIN_FRAME_LEN(MIN_FRAME_LEN),
        .PADDING_EN(PADDING_EN)
    ) u_ctrl (
        .clk(clk), .reset_crc(reset_crc),
        .tdata(tdata), .tvalid(tvalid), .tlast(tlast), .tuser(tuser), .tready(tready),
        .cfg_tx_max_pkt_len(cfg_tx_max_pkt_len), .cfg_tx_ifg(cfg_tx_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .crc_init(crc_init), .crc_update(crc_update),
        .crc_data(crc_data), .crc_state(crc_state),
        .hdr_start(hdr_start), .hdr_byte_valid(hdr_byte_valid), .hdr_data(hdr_data),
        .is_mcast(is_mcast), .is_bcast(is_bcast), .is_vlan(is_vlan),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
        .tx_start_packet(tx_start_packet), .stat_tx_byte(stat_tx_byte),
        .stat_tx_pkt_len(stat_tx_pkt_len),
        .stat_tx_pkt_ucast(stat_tx_pkt_ucast), .stat_tx_pkt_mcast(stat_tx_pkt_mcast),
        .stat_tx_pkt_bcast(stat_tx_pkt_bcast), .stat_tx_pkt_vlan(stat_tx_pkt_vlan),
        .stat_tx_pkt_good(stat_tx_pkt_good), .stat_tx_pkt_bad(stat_tx_pkt_bad),
        .stat_tx_err_oversize(stat_tx_err_oversize), .stat_tx_err_user(stat_tx_err_user),
        .stat_tx_err_underflow(stat_tx_err_underflow)
    );

    gmii_tx_crc32 u_crc32 (
        .clk(clk),
        .crc_init(crc_init),
        .crc_update(crc_update),
        .crc_data(crc_data),
        .crc_state(crc_state)
    );

    gmii_tx_hdr_class u_hdr_class (
        .clk(clk),
        .reset_crc(reset_crc),
        .hdr_start(hdr_start),
        .hdr_byte_valid(hdr_byte_valid),
        .hdr_data(hdr_data),
        .is_mcast(is_mcast),
        .is_bcast(is_bcast),
        .is_vlan(is_vlan)
    );

endmodule

/* verif/gmii_tx_tb.sv */
// GMII transmitter testbench with frame stimulus, GMII monitor, reference FCS and assertions
module gmii_tx_tb;

    import gmii_tx_pkg::*;

    localparam int N_FRAMES = 7;
    localparam int RESET_CYCLES = 8;
    localparam int K_GOOD = 0;
    localparam int K_USER = 1;
    localparam int K_UNDER = 2;
    localparam int K_OVER = 3;

    logic clk;
    logic reset_crc;
    gmii_byte_t tdata;
    logic tvalid, tlast, tuser, tready;
    pkt_len_t cfg_tx_max_pkt_len;
    ifg_len_t cfg_tx_ifg;
    logic cfg_tx_enable;
    gmii_byte_t gmii_txd;
    logic gmii_tx_en, gmii_tx_er, tx_start_packet, stat_tx_byte;
    pkt_len_t stat_tx_pkt_len;
    logic stat_tx_pkt_ucast, stat_tx_pkt_mcast, stat_tx_pkt_bcast, stat_tx_pkt_vlan;
    logic stat_tx_pkt_good, stat_tx_pkt_bad;
    logic stat_tx_err_oversize, stat_tx_err_user, stat_tx_err_underflow;

    int seed = 63;
    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;
    int timeout_limit = 0;
    int frames_done = 0;
    int frm_len [N_FRAMES];
    int frm_kind [N_FRAMES];
    int frm_dst [N_FRAMES];
    bit frm_vlan [N_FRAMES];
    gmii_byte_t frame_buf [0:255];

    // expected payload bytes back to back plus per-frame length and kind
    gmii_byte_t exp_data [$];
    int exp_len_q [$];
    int exp_kind_q [$];

    // monitor state
    gmii_byte_t wire_q [$];
    logic prev_en = 1'b0;
    bit er_seen;
    int sop_cnt, byte_cnt, gap_cnt;

    gmii_tx_top #(.MIN_FRAME_LEN(64), .PADDING_EN(1'b1)) i_dut (.*);

    always #2 clk = ~clk;

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %0t: %s", $time, what);
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks++;
        assert (ok) else report_error(what);
    endtask

    function automatic logic [7:0] reverse8(input logic [7:0] v);
        for (int i = 0; i < 8; i++) reverse8[i] = v[7-i];
    endfunction

    function automatic logic [31:0] reverse32(input logic [31:0] v);
        for (int i = 0; i < 32; i++) reverse32[i] = v[31-i];
    endfunction

    // MSB-first CRC-32 over bit-reversed bytes with the result reflected back and inverted
    function automatic crc_t ref_fcs(input gmii_byte_t data [$], input int count);
        logic [31:0] r;
        gmii_byte_t b;
        r = 32'hFFFF_FFFF;
        for (int i = 0; i < count; i++) begin
            // zero padding past the payload
            b = (i < data.size()) ? data[i] : 8'h00;
            r = r ^ {reverse8(b), 24'h0};
            for (int k = 0; k < 8; k++) begin
                r = r[31] ? ((r << 1) ^ 32'h04C1_1DB7) : (r << 1);
            end
        end
        return ~reverse32(r);
    endfunction

    task automatic send_frame(input int len, input int kind, input int dst, input bit vlan);
        bit acc;
        for (int i = 0; i < len; i++) frame_buf[i] = 8'($random(seed));
        if (dst == 0) frame_buf[0][0] = 1'b0;
        if (dst == 1) begin
            frame_buf[0][0] = 1'b1;
            frame_buf[1] = 8'h00;
        end
        if (dst == 2) for (int i = 0; i < 6; i++) frame_buf[i] = 8'hFF;
        frame_buf[12] = vlan ? 8'h81 : 8'h08;
        frame_buf[13] = 8'h00;
        for (int i = 0; i < len; i++) exp_data.push_back(frame_buf[i]);
        exp_len_q.push_back(len);
        exp_kind_q.push_back(kind);
        for (int i = 0; i < len; i++) begin
            if (kind == K_UNDER && i == 20) begin
                // source stalls mid-frame
                tvalid = 1'b0;
                repeat (3) @(posedge clk);
                #1;
            end
            tdata = frame_buf[i];
            tvalid = 1'b1;
            tlast = (i == len - 1);
            tuser = (kind == K_USER) && (i == len - 1);
            do begin
                @(negedge clk);
                acc = tready;
                @(posedge clk);
                #1;
            end while (!acc);
        end
        tvalid = 1'b0;
        tlast = 1'b0;
        tuser = 1'b0;
    endtask

    task automatic check_frame();
        gmii_byte_t pay [$];
        int plen, kind, dlen, wlen;
        bit bc, mc, vl;
        crc_t fcs;
        if (exp_len_q.size() == 0) begin
            report_error("frame on GMII with no frame sent");
            return;
        end
        plen = exp_len_q.pop_front();
        kind = exp_kind_q.pop_front();
        for (int i = 0; i < plen; i++) pay.push_back(exp_data.pop_front());
        wlen = wire_q.size();
        bc = 1;
        for (int i = 0; i < 6; i++) bc = bc && (pay[i] == 8'hFF);
        mc = pay[0][0] && !bc;
        vl = (pay[12] == 8'h81) && (pay[13] == 8'h00);
        expect_true(wlen >= 8 + 14 + FCS_LEN, "frame too short on GMII");
        for (int i = 0; i < PREAMBLE_LEN; i++) expect_true(wire_q[i] == ETH_PRE, "bad preamble");
        expect_true(wire_q[7] == ETH_SFD, "bad SFD");
        expect_true(sop_cnt == 1, "tx_start_packet not pulsed once");
        expect_true(byte_cnt == wlen - PREAMBLE_LEN, "stat_tx_byte count mismatch");
        expect_true(er_seen == (kind != K_GOOD), "tx_er marking mismatch");
        expect_true(stat_tx_pkt_good == (kind == K_GOOD), "good pulse mismatch");
        expect_true(stat_tx_pkt_bad == (kind != K_GOOD), "bad pulse mismatch");
        expect_true(stat_tx_err_user == (kind == K_USER), "err_user mismatch");
        expect_true(stat_tx_err_underflow == (kind == K_UNDER), "err_underflow mismatch");
        expect_true(stat_tx_err_oversize == (kind == K_OVER), "err_oversize mismatch");
        expect_true(stat_tx_pkt_ucast == !pay[0][0], "ucast mismatch");
        expect_true(stat_tx_pkt_mcast == mc, "mcast mismatch");
        expect_true(stat_tx_pkt_bcast == bc, "bcast mismatch");
        expect_true(stat_tx_pkt_vlan == vl, "vlan mismatch");
        for (int i = 0; i < 14; i++) expect_true(wire_q[8+i] == pay[i], "header byte mismatch");
        if (kind == K_GOOD) begin
            dlen = (plen < 60) ? 60 : plen;
            expect_true(wlen == 8 + dlen + FCS_LEN, "frame length on GMII");
            expect_true(stat_tx_pkt_len == pkt_len_t'(dlen + FCS_LEN), "stat_tx_pkt_len mismatch");
            for (int i = 0; i < dlen; i++) begin
                expect_true(wire_q[8+i] == ((i < plen) ? pay[i] : 8'h00), "payload byte mismatch");
            end
            fcs = ref_fcs(pay, dlen);
            for (int k = 0; k < FCS_LEN; k++) begin
                expect_true(wire_q[8+dlen+k] == fcs[8*k +: 8], "FCS byte mismatch");
            end
        end else if (kind == K_OVER) begin
            expect_true(wlen - 8 - FCS_LEN < plen, "oversize frame not truncated");
        end
        frames_done++;
    endtask

    always @(negedge clk) begin
        if (!reset_crc) begin
            if (gmii_tx_en && !prev_en) begin
                if (frames_done > 0) expect_true(gap_cnt >= int'(cfg_tx_ifg), "gap too short");
                wire_q.delete();
                er_seen = 0;
                sop_cnt = 0;
                byte_cnt = 0;
                gap_cnt = 0;
            end
            if (gmii_tx_en) begin
                wire_q.push_back(gmii_txd);
                er_seen = er_seen || gmii_tx_er;
            end else begin
                gap_cnt++;
            end
            if (tx_start_packet) sop_cnt++;
            if (stat_tx_byte) byte_cnt++;
            // statistics land in the first cycle after the last FCS byte
            if (!gmii_tx_en && prev_en) check_frame();
            prev_en = gmii_tx_en;
        end
    end

    a_er_needs_en: assert property (@(posedge clk) disable iff (reset_crc)
        gmii_tx_er |-> gmii_tx_en) else report_error("tx_er outside tx_en");
    a_sop_after_sfd: assert property (@(posedge clk) disable iff (reset_crc)
        tx_start_packet |-> $past(gmii_txd) == ETH_SFD) else report_error("start strobe misplaced");
    a_byte_in_frame: assert property (@(posedge clk) disable iff (reset_crc)
        stat_tx_byte |-> gmii_tx_en) else report_error("stat_tx_byte outside frame");
    a_good_bad_excl: assert property (@(posedge clk) disable iff (reset_crc)
        !(stat_tx_pkt_good && stat_tx_pkt_bad)) else report_error("good and bad together");

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the DUT did not finish all frames in %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int total;
        clk = 1'b0;
        reset_crc = 1'b1;
        tdata = '0;
        tvalid = 1'b0;
        tlast = 1'b0;
        tuser = 1'b0;
        cfg_tx_max_pkt_len = 16'd100;
        cfg_tx_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        frm_len = '{20, 72, 64, 40, 30, 150, 60};
        frm_kind = '{K_GOOD, K_GOOD, K_GOOD, K_USER, K_UNDER, K_OVER, K_GOOD};
        frm_dst = '{0, 2, 1, 0, 1, 0, 0};
        frm_vlan = '{0, 0, 1, 0, 0, 1, 0};
        // preamble, padded data, FCS, gap and a little slack per frame
        total = RESET_CYCLES;
        for (int f = 0; f < N_FRAMES; f++) begin
            total += 8 + ((frm_len[f] < 60) ? 60 : frm_len[f]) + FCS_LEN + 12 + 8;
        end
        timeout_limit = 2 * total;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        @(negedge clk);
        expect_true(!tready && !gmii_tx_en && !gmii_tx_er, "outputs not idle after reset");
        expect_true(!stat_tx_byte && !tx_start_packet && !stat_tx_pkt_good, "strobes after reset");
        @(posedge clk);
        #1;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(frm_len[f], frm_kind[f], frm_dst[f], frm_vlan[f]);
        end
        wait (frames_done == N_FRAMES);
        repeat (4) @(negedge clk);
        expect_true(!gmii_tx_en && !tready, "DUT not idle after the last frame");
        $display("checks %0d, errors %0d, frames %0d", checks, errors, frames_done);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
